// ==== snake_cfg.svh ====
// Snake game configuration with grid size, timing, queue depth and apple seed.
`ifndef SNAKE_CFG_SVH
`define SNAKE_CFG_SVH

// Playfield size in cells.
`define SNAKE_GRID_X 40
`define SNAKE_GRID_Y 30

`define SNAKE_MAX_LEN 16          // number of body segments, head included.

`define SNAKE_STEP_CYCLES 64      // clocks per movement step.
`define SNAKE_DEBOUNCE_CYCLES 4   // clocks a key level must hold before it counts.
`define SNAKE_DIE_CYCLES 128      // clocks spent in the die status before the end.

`define SNAKE_FIFO_DEPTH 4
`define SNAKE_APPLE_SEED 16'hACE1

`endif

// ==== snake_cmd_pkg.sv ====
// Input side types for the snake game, the raw key bundle and the direction command.
package snake_cmd_pkg;

	typedef struct packed {
		logic left;
		logic right;
		logic up;
		logic down;
	} key_raw_t;

	// opposite directions differ only in bit 0.
	typedef enum logic [1:0] {
		DIR_UP    = 2'd0,
		DIR_DOWN  = 2'd1,
		DIR_LEFT  = 2'd2,
		DIR_RIGHT = 2'd3
	} dir_t;

	function automatic dir_t dir_reverse(input dir_t d);
		return dir_t'(d ^ 2'b01);
	endfunction

endpackage

// ==== snake_state_pkg.sv ====
// Game side types for the snake game, status, grid cells and the observed game view.
package snake_state_pkg;

	typedef enum logic [1:0] {
		ST_START = 2'd0,
		ST_PLAY  = 2'd1,
		ST_DIE   = 2'd2,
		ST_END   = 2'd3
	} status_t;

	typedef struct packed {
		logic [5:0] x;
		logic [5:0] y;
	} cell_t;

	// Everything an observer needs about the running game.
	typedef struct packed {
		cell_t      head;
		cell_t      apple;
		logic [4:0] length;
		status_t    status;
	} snake_view_t;

endpackage

// ==== key_press.sv ====
// Key front end that debounces the four buttons and turns each new press into a direction command.
`include "snake_cfg.svh"

module key_press (
	input  logic                    clk,
	input  logic                    arst_n,
	input  snake_cmd_pkg::key_raw_t keys,
	output snake_cmd_pkg::dir_t     cmd,
	output logic                    cmd_valid,
	input  logic                    cmd_ready
);
	import snake_cmd_pkg::*;

	localparam int DEB = `SNAKE_DEBOUNCE_CYCLES;
	localparam int CW = $clog2(DEB + 1);

	logic [3:0] sync_a;
	logic [3:0] sync_b;
	logic [3:0] level;
	logic [3:0] done;
	logic [CW-1:0] cnt [4];
	key_raw_t rise;

	always_comb begin
		for (int i = 0; i < 4; i++)
			done[i] = (sync_b[i] != level[i]) && (cnt[i] == CW'(DEB - 1)); // level held long enough.
	end

	assign rise = key_raw_t'(done & sync_b); // only new presses, releases are ignored.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			sync_a <= '0;
			sync_b <= '0;
			level <= '0;
			for (int i = 0; i < 4; i++)
				cnt[i] <= '0;
		end else begin
			sync_a <= keys;
			sync_b <= sync_a;
			level <= level ^ done;
			for (int i = 0; i < 4; i++) begin
				if (sync_b[i] == level[i] || done[i])
					cnt[i] <= '0;
				else
					cnt[i] <= cnt[i] + 1'b1;
			end
		end
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n)
			cmd_valid <= 1'b0;
		else if (!cmd_valid || cmd_ready)
			cmd_valid <= |rise; // a press during back-pressure is lost.
	end

	always_ff @(posedge clk) begin
		if ((!cmd_valid || cmd_ready) && (|rise)) begin
			if (rise.up)
				cmd <= DIR_UP;
			else if (rise.down)
				cmd <= DIR_DOWN;
			else if (rise.left)
				cmd <= DIR_LEFT;
			else
				cmd <= DIR_RIGHT;
		end
	end

endmodule

// ==== cmd_fifo.sv ====
// Show-ahead command queue that buffers direction commands between the keys and the engine.
`include "snake_cfg.svh"

module cmd_fifo (
	input  logic                clk,
	input  logic                arst_n,
	input  snake_cmd_pkg::dir_t in_cmd,
	input  logic                in_valid,
	output logic                in_ready,
	output snake_cmd_pkg::dir_t out_cmd,
	output logic                out_valid,
	input  logic                out_ready
);
	import snake_cmd_pkg::*;

	localparam int DEPTH = `SNAKE_FIFO_DEPTH;
	localparam int AW = $clog2(DEPTH);

	dir_t mem [DEPTH];
	logic [AW-1:0] wr_ptr;
	logic [AW-1:0] rd_ptr;
	logic [AW:0] count;
	logic [AW:0] count_n;
	logic wr;
	logic rd;

	assign wr = in_valid && in_ready;
	assign rd = out_valid && out_ready;
	assign out_valid = (count != '0);
	assign out_cmd = mem[rd_ptr]; // head is visible without a read strobe.

	always_comb begin
		count_n = count;
		case ({wr, rd})
			2'b10: count_n = count + 1'b1;
			2'b01: count_n = count - 1'b1;
			default: ;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			in_ready <= 1'b0;
		end else begin
			count <= count_n;
			in_ready <= (count_n != (AW + 1)'(DEPTH)); // registered so it is low during reset.
			if (wr)
				wr_ptr <= (wr_ptr == AW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (rd)
				rd_ptr <= (rd_ptr == AW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (wr)
			mem[wr_ptr] <= in_cmd;
	end

endmodule

// ==== apple_gen.sv ====
// Apple placer that draws a new apple cell from a free-running LFSR each time one is eaten.
`include "snake_cfg.svh"

module apple_gen (
	input  logic                   clk,
	input  logic                   arst_n,
	input  logic                   eat,
	output snake_state_pkg::cell_t apple
);
	import snake_state_pkg::*;

	localparam logic [5:0] GX = 6'(`SNAKE_GRID_X);
	localparam logic [5:0] GY = 6'(`SNAKE_GRID_Y);

	logic [15:0] lfsr;
	logic fb;

	function automatic logic [5:0] wrap(input logic [5:0] v, input logic [5:0] lim);
		logic [5:0] r;
		r = (v >= lim) ? v - lim : v;
		return (r >= lim) ? r - lim : r; // second pass for rows above twice the height.
	endfunction

	function automatic cell_t place(input logic [15:0] s);
		return '{x: wrap(s[5:0], GX), y: wrap(s[13:8], GY)};
	endfunction

	assign fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10]; // taps 16, 14, 13 and 11.

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			lfsr <= 16'(`SNAKE_APPLE_SEED);
			apple <= place(16'(`SNAKE_APPLE_SEED)); // first apple comes straight from the seed.
		end else begin
			lfsr <= {lfsr[14:0], fb};
			if (eat)
				apple <= place(lfsr);
		end
	end

endmodule

// ==== snake_engine.sv ====
// Snake engine that steps the snake, grows it, detects wall and body hits and runs the game status.
`include "snake_cfg.svh"

module snake_engine (
	input  logic                         clk,
	input  logic                         arst_n,
	input  snake_cmd_pkg::dir_t          q_cmd,
	input  logic                         q_valid,
	output logic                         q_ready,
	input  snake_state_pkg::cell_t       apple,
	output logic                         eat,
	output logic                         step,
	output snake_state_pkg::snake_view_t view
);
	import snake_cmd_pkg::*;
	import snake_state_pkg::*;

	localparam int GRID_X = `SNAKE_GRID_X;
	localparam int GRID_Y = `SNAKE_GRID_Y;
	localparam int MAX_LEN = `SNAKE_MAX_LEN;
	localparam int STEP = `SNAKE_STEP_CYCLES;
	localparam int DIE = `SNAKE_DIE_CYCLES;
	localparam int CW = $clog2((DIE > STEP) ? DIE : STEP);
	localparam logic [5:0] START_X = 6'd10;
	localparam logic [5:0] START_Y = 6'd10;
	localparam logic [4:0] START_LEN = 5'd3;

	status_t status;
	status_t status_n;
	dir_t dir;
	dir_t dir_n;
	cell_t body [MAX_LEN];
	cell_t nxt;
	logic [4:0] len;
	logic [CW-1:0] cnt;
	logic [CW-1:0] cnt_n;
	logic take;
	logic tick;
	logic hit_wall;
	logic hit_body;
	logic eat_now;

	assign take = q_valid && q_ready;
	assign tick = (status == ST_PLAY) && (cnt == CW'(STEP - 1));
	assign dir_n = (take && (q_cmd != dir_reverse(dir))) ? q_cmd : dir; // reversing is refused.
	assign eat_now = tick && !hit_wall && !hit_body && (nxt == apple);
	assign view = '{head: body[0], apple: apple, length: len, status: status};

	// ########################################
	// next head and hit detection
	// ########################################

	always_comb begin
		nxt = body[0];
		case (dir_n)
			DIR_UP: nxt.y = body[0].y - 1'b1;
			DIR_DOWN: nxt.y = body[0].y + 1'b1;
			DIR_LEFT: nxt.x = body[0].x - 1'b1;
			default: nxt.x = body[0].x + 1'b1;
		endcase
		hit_wall = (nxt.x >= 6'(GRID_X)) || (nxt.y >= 6'(GRID_Y)); // wrap below zero lands here too.
	end

	always_comb begin
		hit_body = 1'b0;
		for (int i = 1; i < MAX_LEN; i++) begin
			if ((i + 1 < int'(len)) && (body[i] == nxt))
				hit_body = 1'b1; // the tail slot is skipped since it moves away this step.
		end
	end

	// ########################################
	// status sequence
	// ########################################

	always_comb begin
		status_n = status;
		cnt_n = '0;
		case (status)
			ST_START: if (take) status_n = ST_PLAY;
			ST_PLAY: begin
				cnt_n = tick ? '0 : cnt + 1'b1;
				if (tick && (hit_wall || hit_body))
					status_n = ST_DIE;
			end
			ST_DIE: begin
				cnt_n = cnt + 1'b1;
				if (cnt == CW'(DIE - 1)) begin
					status_n = ST_END;
					cnt_n = '0;
				end
			end
			default: if (take) status_n = ST_START;
		endcase
	end

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			status <= ST_START;
			cnt <= '0;
			dir <= DIR_RIGHT;
			len <= START_LEN;
			q_ready <= 1'b0;
			step <= 1'b0;
			eat <= 1'b0;
		end else begin
			status <= status_n;
			cnt <= cnt_n;
			q_ready <= (status_n == ST_START) || (status_n == ST_END) ||
				(status_n == ST_PLAY && cnt_n == CW'(STEP - 1)); // one command per step.
			step <= tick && !hit_wall && !hit_body;
			eat <= eat_now;
			dir <= (status_n == ST_START) ? DIR_RIGHT : dir_n;
			if (status_n == ST_START)
				len <= START_LEN;
			else if (eat_now && len != 5'(MAX_LEN))
				len <= len + 1'b1;
		end
	end

	// Growth needs no special case, the old tail simply shifts into the next slot.
	always_ff @(posedge clk) begin
		if (status_n == ST_START) begin
			for (int i = 0; i < MAX_LEN; i++) begin
				body[i].x <= (i < int'(START_LEN)) ? START_X - 6'(i) : START_X - 6'(START_LEN - 1);
				body[i].y <= START_Y;
			end
		end else if (tick && !hit_wall && !hit_body) begin
			body[0] <= nxt;
			for (int i = 1; i < MAX_LEN; i++)
				body[i] <= body[i - 1];
		end
	end

endmodule

// ==== snake_top.sv ====
// Snake game core top level joining the key front end, the command queue, the engine and the apple placer.
module snake_top (
	input  logic                         clk,
	input  logic                         arst_n,
	input  snake_cmd_pkg::key_raw_t      keys,
	output snake_state_pkg::snake_view_t view,
	output logic                         step
);
	import snake_cmd_pkg::*;
	import snake_state_pkg::*;

	dir_t cmd;
	logic cmd_valid;
	logic cmd_ready;
	dir_t q_cmd;
	logic q_valid;
	logic q_ready;
	logic eat;
	cell_t apple;

	key_press u_key_press (
		.clk(clk),
		.arst_n(arst_n),
		.keys(keys),
		.cmd(cmd),
		.cmd_valid(cmd_valid),
		.cmd_ready(cmd_ready)
	);

	cmd_fifo u_cmd_fifo (
		.clk(clk),
		.arst_n(arst_n),
		.in_cmd(cmd),
		.in_valid(cmd_valid),
		.in_ready(cmd_ready),
		.out_cmd(q_cmd),
		.out_valid(q_valid),
		.out_ready(q_ready)
	);

	snake_engine u_snake_engine (
		.clk(clk),
		.arst_n(arst_n),
		.q_cmd(q_cmd),
		.q_valid(q_valid),
		.q_ready(q_ready),
		.apple(apple),
		.eat(eat),
		.step(step),
		.view(view)
	);

	apple_gen u_apple_gen (
		.clk(clk),
		.arst_n(arst_n),
		.eat(eat),
		.apple(apple)
	);

endmodule

// ==== snake_chk.sv ====
// Snake core checker with concurrent assertions on command handshakes, step status and apple range.
`include "snake_cfg.svh"

module snake_chk (
	input logic                         clk,
	input logic                         arst_n,
	input snake_cmd_pkg::dir_t          cmd,
	input logic                         cmd_valid,
	input logic                         cmd_ready,
	input snake_cmd_pkg::dir_t          q_cmd,
	input logic                         q_valid,
	input logic                         q_ready,
	input logic                         step,
	input snake_state_pkg::snake_view_t view,
	input snake_state_pkg::cell_t       apple
);
	timeunit 1ns;
	timeprecision 1ps;
	import snake_cmd_pkg::*;
	import snake_state_pkg::*;

	// a waiting command may not change or vanish before it is taken.
	a_key_cmd_hold: assert property (@(posedge clk) disable iff (!arst_n)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd))
		else $error("key command changed while the queue was full");

	a_queue_cmd_hold: assert property (@(posedge clk) disable iff (!arst_n)
		q_valid && !q_ready |=> q_valid && $stable(q_cmd))
		else $error("queued command changed while the engine was busy");

	a_step_in_play: assert property (@(posedge clk) disable iff (!arst_n)
		step |-> view.status == ST_PLAY)
		else $error("step pulse outside the play status");

	a_apple_in_grid: assert property (@(posedge clk) disable iff (!arst_n)
		(apple.x < 6'(`SNAKE_GRID_X)) && (apple.y < 6'(`SNAKE_GRID_Y)))
		else $error("apple placed outside the grid");

endmodule

bind snake_top snake_chk u_chk (
	.clk(clk),
	.arst_n(arst_n),
	.cmd(cmd),
	.cmd_valid(cmd_valid),
	.cmd_ready(cmd_ready),
	.q_cmd(q_cmd),
	.q_valid(q_valid),
	.q_ready(q_ready),
	.step(step),
	.view(view),
	.apple(apple)
);

// ==== snake_tb.sv ====
// Snake core testbench that replays key cases from a file and checks the game view after each.
`include "snake_cfg.svh"

module snake_tb;
	timeunit 1ns;
	timeprecision 1ps;
	import snake_cmd_pkg::*;
	import snake_state_pkg::*;

	localparam int STEP_TIMEOUT = 4 * `SNAKE_STEP_CYCLES;
	localparam int STATUS_TIMEOUT = 4 * `SNAKE_DIE_CYCLES;
	localparam int HOLD_CYCLES = 2 * `SNAKE_DEBOUNCE_CYCLES;

	logic clk;
	logic arst_n;
	key_raw_t keys;
	snake_view_t view;
	logic step;

	int fd;
	int n_case;
	int key_code;
	int steps;
	int exp_x;
	int exp_y;
	int exp_len;
	int exp_st;
	string line;
	string name;
	cell_t last_apple;
	logic [4:0] last_len;

	snake_top u_dut (
		.clk(clk),
		.arst_n(arst_n),
		.keys(keys),
		.view(view),
		.step(step)
	);

	always #20 clk = ~clk;

	// apple cell that the seed rule gives for one LFSR state.
	function automatic cell_t seed_apple(input logic [15:0] s);
		cell_t c;
		c.x = s[5:0];
		c.y = s[13:8];
		if (c.x >= 6'(`SNAKE_GRID_X))
			c.x = c.x - 6'(`SNAKE_GRID_X);
		if (c.y >= 6'(`SNAKE_GRID_Y))
			c.y = c.y - 6'(`SNAKE_GRID_Y);
		return c;
	endfunction

	task automatic stop_on_error(input string msg);
		$display("%s", msg);
		$display("Checks failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string what, input int exp, input int act);
		assert (exp == act) else begin
			$display("Error %s %s expected %0d actual %0d", name, what, exp, act);
			$display("Checks failed");
			$fatal(1, "value mismatch");
		end
	endtask

	task automatic press_key(input int code);
		key_raw_t k;
		k = '0;
		case (code)
			1: k.up = 1'b1;
			2: k.down = 1'b1;
			3: k.left = 1'b1;
			4: k.right = 1'b1;
			default: ;
		endcase
		if (code != 0) begin
			@(posedge clk);
			#2 keys = k;
			repeat (HOLD_CYCLES) @(posedge clk);
			#2 keys = '0;
			repeat (HOLD_CYCLES) @(posedge clk); // release has to debounce as well.
		end
	endtask

	task automatic wait_step();
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > STEP_TIMEOUT)
				stop_on_error($sformatf("timeout waiting for a step pulse in case %s", name));
		end while (step !== 1'b1);
	endtask

	task automatic wait_status(input int st);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
			if (n > STATUS_TIMEOUT)
				stop_on_error($sformatf("timeout waiting for status %0d in case %s", st, name));
		end while (int'(view.status) != st);
	endtask

	task automatic run_case();
		press_key(key_code);
		if (steps > 0) begin
			repeat (steps) wait_step();
			repeat (2) @(negedge clk); // lets a new apple settle after an eat.
		end else begin
			wait_status(exp_st);
		end
		check_value("head x", exp_x, int'(view.head.x));
		check_value("head y", exp_y, int'(view.head.y));
		check_value("length", exp_len, int'(view.length));
		check_value("status", exp_st, int'(view.status));
		if (n_case == 0)
			check_value("seed apple", int'(seed_apple(`SNAKE_APPLE_SEED)), int'(view.apple));
		check_value("apple x in grid", 1, int'(view.apple.x < 6'(`SNAKE_GRID_X)));
		check_value("apple y in grid", 1, int'(view.apple.y < 6'(`SNAKE_GRID_Y)));
		if (n_case > 0 && view.length > last_len)
			check_value("apple moved after eat", 1, int'(view.apple != last_apple));
		last_apple = view.apple;
		last_len = view.length;
		n_case++;
	endtask

	// ########################################
	// main sequence
	// ########################################

	initial begin
		clk = 1'b0;
		arst_n = 1'b0;
		keys = '0;
		n_case = 0;
		repeat (10) @(posedge clk);
		#2 arst_n = 1'b1;
		@(negedge clk);
		fd = $fopen("snake_cases.txt", "r");
		if (fd == 0)
			stop_on_error("cannot open the case file snake_cases.txt");
		while (!$feof(fd)) begin
			if ($fgets(line, fd) != 0 && line.len() > 1 && line[0] != "#") begin
				if ($sscanf(line, "%s %d %d %d %d %d %d", name, key_code, steps,
					exp_x, exp_y, exp_len, exp_st) != 7)
					stop_on_error($sformatf("malformed case line: %s", line));
				run_case();
			end
		end
		$fclose(fd);
		if (n_case > 0) begin
			$display("All checks passed");
			$finish;
		end else begin
			stop_on_error("no cases were read from snake_cases.txt");
		end
	end

endmodule

// ==== snake_cases.txt ====
# name key steps head_x head_y length status (steps 0 waits for the status)
# key 0 none 1 up 2 down 3 left 4 right, status 0 start 1 play 2 die 3 end
reset 0 0 10 10 3 0
start_right 4 1 11 10 3 1
reverse_left 3 1 12 10 3 1
turn_down 2 1 12 11 3 1
queue_right 4 0 12 11 3 1
queue_down 2 1 13 11 3 1
queued_down_applied 0 1 13 12 3 1
down_to_apple_row 0 2 13 14 3 1
right_to_apple 4 20 33 14 4 1
run_to_wall 0 6 39 14 4 1
hit_wall 0 0 39 14 4 2
die_to_end 0 0 39 14 4 3
restart 4 0 10 10 3 0
start_up 1 1 10 9 3 1

// ==== project.f ====
+incdir+.
snake_cmd_pkg.sv
snake_state_pkg.sv
key_press.sv
cmd_fifo.sv
apple_gen.sv
snake_engine.sv
snake_top.sv
snake_chk.sv
snake_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the snake testbench with Verilator and runs it from the project root.
verilator --binary --timing --assert --timescale 1ns/1ps -f project.f \
	--top-module snake_tb -o snake_sim &&
	./obj_dir/snake_sim | tee /dev/stderr | grep -q "All checks passed" &&
	echo "PASS" || { echo "FAIL"; exit 1; }
